//--- design/hangman_pkg.sv
`default_nettype none

package hangman_pkg;

    localparam int word_len     = 5;    // letters in the secret word
    localparam int guess_slots  = 6;    // wrong letters kept on screen
    localparam int max_mistakes = 6;    // mistakes that lose the game
    localparam int row_width    = 128;  // 16 characters per lcd row
    localparam int fifo_depth   = 4;
    localparam int fifo_ptr_w   = $clog2(fifo_depth);
    localparam int fifo_cnt_w   = $clog2(fifo_depth + 1);

    localparam logic [7:0]  char_blank = 8'h5F;            // '_'
    localparam logic [23:0] text_win   = 24'h57_69_6E;     // "Win"
    localparam logic [31:0] text_lose  = 32'h4C_6F_73_65;  // "Lose"

    // zero padding on each side of a centered field
    localparam int pad_word = (row_width - 8 * word_len) / 2;
    localparam int pad_hist = (row_width - 8 * guess_slots) / 2;
    localparam int pad_win  = (row_width - $bits(text_win)) / 2;
    localparam int pad_lose = (row_width - $bits(text_lose)) / 2;

    typedef logic [row_width-1:0] row_t;

    typedef struct packed {
        logic [7:0]          letter;
        logic [word_len-1:0] hits;           // msb is the first letter
        logic                mistake;
        logic [2:0]          correct_count;  // revealed positions after this guess
        logic [2:0]          mistake_count;
        logic                restart;        // marks a new game
    } guess_event_t;

    typedef struct packed {
        row_t top;
        row_t bottom;
    } lcd_rows_t;

endpackage

`default_nettype wire

//--- design/guess_checker.sv
`timescale 1ns/100ps
`default_nettype none

module guess_checker (
    input  logic                               clk,
    input  logic                               nRst,
    input  logic                               guess,
    input  logic [7:0]                         letter,
    input  logic [8*hangman_pkg::word_len-1:0] word,
    input  logic                               new_game,
    input  logic                               full,
    output logic                               push,
    output hangman_pkg::guess_event_t          evt
);
    import hangman_pkg::*;

    logic [word_len-1:0] mask;          // positions revealed so far
    logic [2:0]          mistakes;
    logic                hold_new;      // new_game waiting for fifo room
    logic [word_len-1:0] hits;
    logic [word_len-1:0] next_mask;
    logic [2:0]          next_mistakes;
    logic                game_over;
    logic                room;
    logic                restart_req;
    logic                take_restart;
    logic                take_guess;

    function automatic logic [2:0] count_ones(input logic [word_len-1:0] m);
        logic [2:0] n;
        n = '0;
        for (int i = 0; i < word_len; i++) begin
            n = n + 3'(m[i]);
        end
        return n;
    endfunction

    always_comb begin
        for (int i = 0; i < word_len; i++) begin
            hits[i] = (word[8*i +: 8] == letter);  // word and hits both msb first
        end
    end

    assign next_mask     = mask | hits;
    assign next_mistakes = (hits == '0 && mistakes != 3'(max_mistakes)) ? mistakes + 3'd1
                                                                       : mistakes;
    assign game_over     = (count_ones(mask) == 3'(word_len)) || (mistakes == 3'(max_mistakes));

    // an event still in flight may take the last fifo slot
    assign room         = !full && !push;
    assign restart_req  = new_game || hold_new;
    assign take_restart = restart_req && room;
    assign take_guess   = guess && room && !restart_req && !game_over;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            mask     <= '0;
            mistakes <= '0;
            hold_new <= 1'b0;
            push     <= 1'b0;
        end else begin
            push <= take_restart || take_guess;
            if (take_restart) begin
                mask     <= '0;
                mistakes <= '0;
                hold_new <= 1'b0;
            end else if (restart_req) begin
                hold_new <= 1'b1;  // fifo busy, retry later
            end else if (take_guess) begin
                mask     <= next_mask;
                mistakes <= next_mistakes;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_restart) begin
            evt <= '{letter: 8'h00, hits: '0, mistake: 1'b0, correct_count: 3'd0,
                     mistake_count: 3'd0, restart: 1'b1};
        end else if (take_guess) begin
            evt <= '{letter: letter, hits: hits, mistake: (hits == '0),
                     correct_count: count_ones(next_mask),
                     mistake_count: next_mistakes, restart: 1'b0};
        end
    end

endmodule

`default_nettype wire

//--- design/event_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module event_fifo #(
    parameter type payload_t = hangman_pkg::guess_event_t
) (
    input  logic     clk,
    input  logic     nRst,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t dout,
    output logic     full,
    output logic     pending
);
    import hangman_pkg::*;

    payload_t              mem [fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_cnt_w-1:0] count;   // entries held
    logic                  do_push;
    logic                  do_pop;

    function automatic logic [fifo_ptr_w-1:0] bump(input logic [fifo_ptr_w-1:0] p);
        return (p == fifo_ptr_w'(fifo_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full    = (count == fifo_cnt_w'(fifo_depth));
    assign pending = (count != '0);
    assign do_push = push && !full;     // push into a full buffer is lost
    assign do_pop  = pop && pending;
    assign dout    = mem[rd_ptr];       // head shown without delay

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= bump(wr_ptr);
            if (do_pop) rd_ptr <= bump(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none or both
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= din;
    end

endmodule

`default_nettype wire

//--- design/host_display.sv
`timescale 1ns/100ps
`default_nettype none

module host_display (
    input  logic                               clk,
    input  logic                               nRst,
    input  logic                               pending,
    input  hangman_pkg::guess_event_t          head,
    input  logic [8*hangman_pkg::word_len-1:0] word,
    input  logic                               lcd_ready,
    output logic                               pop,
    output hangman_pkg::lcd_rows_t             rows
);
    import hangman_pkg::*;

    logic [8*word_len-1:0]    shown;        // word with hidden letters as '_'
    logic [8*word_len-1:0]    next_shown;
    logic [8*guess_slots-1:0] hist;         // newest wrong letter at the msb
    logic [8*guess_slots-1:0] next_hist;
    lcd_rows_t                next_rows;
    logic                     won;
    logic                     lost;

    // place a field in the middle of a row, zeros either side
    function automatic row_t center(input row_t field, input int pad);
        return field << pad;
    endfunction

    assign pop = pending && lcd_ready;

    assign won  = !head.restart && (head.correct_count == 3'(word_len));
    assign lost = !head.restart && (head.mistake_count == 3'(max_mistakes));

    // game state after the head event
    always_comb begin
        next_shown = shown;
        next_hist  = hist;
        if (head.restart) begin
            next_shown = {word_len{char_blank}};
            next_hist  = {guess_slots{char_blank}};
        end else begin
            for (int i = 0; i < word_len; i++) begin
                if (head.hits[i]) next_shown[8*i +: 8] = head.letter;
            end
            if (head.mistake) begin
                next_hist = {head.letter, hist[8*guess_slots-1:8]};  // oldest drops out
            end
        end
    end

    // screen for the head event
    always_comb begin
        if (won) begin
            next_rows.top    = center(row_t'(text_win), pad_win);
            next_rows.bottom = center(row_t'(word), pad_word);
        end else if (lost) begin
            next_rows.top    = center(row_t'(text_lose), pad_lose);
            next_rows.bottom = center(row_t'(word), pad_word);
        end else begin
            // play screen shows the state after this event
            next_rows.top    = center(row_t'(next_shown), pad_word);
            next_rows.bottom = center(row_t'(next_hist), pad_hist);
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            rows  <= '0;
            shown <= {word_len{char_blank}};
            hist  <= {guess_slots{char_blank}};
        end else if (pop) begin
            rows  <= next_rows;
            shown <= next_shown;
            hist  <= next_hist;
        end
    end

endmodule

`default_nettype wire

//--- design/hangman_host.sv
`timescale 1ns/100ps
`default_nettype none

module hangman_host (
    input  logic                               clk,
    input  logic                               nRst,
    input  logic                               guess,
    input  logic [7:0]                         letter,
    input  logic [8*hangman_pkg::word_len-1:0] word,      // held for a whole game
    input  logic                               new_game,
    input  logic                               lcd_ready,
    output hangman_pkg::lcd_rows_t             rows,
    output logic                               full,
    output logic                               pending
);
    import hangman_pkg::*;

    logic         push;
    logic         pop;
    guess_event_t evt;   // checker output
    guess_event_t head;  // oldest queued event

    guess_checker checker0 (
        .clk      (clk),
        .nRst     (nRst),
        .guess    (guess),
        .letter   (letter),
        .word     (word),
        .new_game (new_game),
        .full     (full),
        .push     (push),
        .evt      (evt)
    );

    event_fifo #(
        .payload_t (guess_event_t)
    ) fifo0 (
        .clk     (clk),
        .nRst    (nRst),
        .push    (push),
        .din     (evt),
        .pop     (pop),
        .dout    (head),
        .full    (full),
        .pending (pending)
    );

    host_display display0 (
        .clk       (clk),
        .nRst      (nRst),
        .pending   (pending),
        .head      (head),
        .word      (word),
        .lcd_ready (lcd_ready),
        .pop       (pop),
        .rows      (rows)
    );

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

endmodule

`default_nettype wire

//--- sim/hangman_asserts.sv
`timescale 1ns/100ps
`default_nettype none

// watches the fifo and display links inside the top level
module hangman_asserts (
    input logic                   clk,
    input logic                   nRst,
    input logic                   push,
    input logic                   full,
    input logic                   pop,
    input logic                   pending,
    input hangman_pkg::lcd_rows_t rows
);
    no_push_when_full: assert property (@(posedge clk) disable iff (!nRst) push |-> !full)
        else $error("event pushed into a full fifo");

    // queued events leave only through the display
    pending_falls_on_pop: assert property (@(posedge clk) disable iff (!nRst)
        $fell(pending) |-> $past(pop))
        else $error("fifo emptied without a pop");

    rows_hold: assert property (@(posedge clk) disable iff (!nRst) !pop |=> $stable(rows))
        else $error("lcd rows changed without a pop");

endmodule

bind hangman_host hangman_asserts asserts0 (
    .clk     (clk),
    .nRst    (nRst),
    .push    (push),
    .full    (full),
    .pop     (pop),
    .pending (pending),
    .rows    (rows)
);

`default_nettype wire

//--- sim/hangman_tb.sv
`timescale 1ns/100ps
`default_nettype none

module hangman_tb;
    import hangman_pkg::*;

    localparam int action_cost  = 10;   // two drive cycles plus a drain under random lcd_ready
    localparam int action_count = 100;  // guesses and new games over all tests
    localparam int max_cycles   = 4 * action_cost * action_count;

    logic        clk;
    logic        nRst;
    logic        guess;
    logic [7:0]  letter;
    logic [39:0] word;
    logic        new_game;
    logic        lcd_ready;
    lcd_rows_t   rows;
    logic        full;
    logic        pending;

    int   seed       = 22;
    int   errors     = 0;
    int   checks     = 0;
    int   cycles     = 0;
    int   test_start = 0;
    int   ready_mode = 1;     // 0 low, 1 random, 2 high
    logic check_req  = 1'b0;

    // reference model of the game
    logic        m_any;       // some event reached the screen
    logic [39:0] m_word;
    logic [4:0]  m_mask;      // msb is the first letter
    logic [47:0] m_hist;      // newest wrong letter first
    int          m_mistakes;
    int          bp_queued;   // events parked while lcd_ready is low

    logic [39:0] words [4] = '{"crane", "queue", "dodge", "zesty"};

    tb_clock clock0 (.clk(clk));

    hangman_host dut0 (
        .clk       (clk),
        .nRst      (nRst),
        .guess     (guess),
        .letter    (letter),
        .word      (word),
        .new_game  (new_game),
        .lcd_ready (lcd_ready),
        .rows      (rows),
        .full      (full),
        .pending   (pending)
    );

    function automatic lcd_rows_t expected_rows(input logic any, input logic [39:0] w,
                                                input logic [4:0] mask, input logic [47:0] hist,
                                                input int mistakes);
        lcd_rows_t   r;
        logic [39:0] shown;
        int          n;
        shown = "_____";
        n     = 0;
        for (int i = 0; i < 5; i++) begin
            if (mask[i]) begin
                shown[8*i +: 8] = w[8*i +: 8];
                n++;
            end
        end
        if (!any) begin
            r = '0;
        end else if (n == 5) begin
            r.top    = {52'd0, "Win", 52'd0};
            r.bottom = {44'd0, w, 44'd0};
        end else if (mistakes == 6) begin
            r.top    = {48'd0, "Lose", 48'd0};
            r.bottom = {44'd0, w, 44'd0};
        end else begin
            r.top    = {44'd0, shown, 44'd0};
            r.bottom = {40'd0, hist, 40'd0};
        end
        return r;
    endfunction

    function automatic logic model_over();
        return (m_mask == 5'b11111) || (m_mistakes == 6);
    endfunction

    function automatic logic [7:0] pick_letter(input logic [39:0] w);
        int unsigned r;
        r = $random(seed);
        if (r[0]) return w[8*((r >> 1) % 5) +: 8];  // a letter of the word
        return 8'h61 + 8'((r >> 1) % 26);
    endfunction

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic model_guess(input logic [7:0] l);
        logic [4:0] hits;
        hits = '0;
        for (int i = 0; i < 5; i++) begin
            if (m_word[8*i +: 8] == l) hits[i] = 1'b1;
        end
        m_any  = 1'b1;
        m_mask = m_mask | hits;
        if (hits == '0) begin
            if (m_mistakes < 6) m_mistakes++;
            m_hist = {l, m_hist[47:8]};
        end
    endtask

    // one cycle pulse, then one idle cycle
    task automatic drive_guess(input logic [7:0] l);
        guess  = 1'b1;
        letter = l;
        @(negedge clk);
        guess = 1'b0;
        @(negedge clk);
    endtask

    task automatic send_guess(input logic [7:0] l);
        logic accepted;
        while (full) @(negedge clk);
        accepted = !model_over();
        drive_guess(l);
        if (accepted) model_guess(l);
    endtask

    // no wait for room, the model predicts the drop
    task automatic force_guess(input logic [7:0] l);
        logic accepted;
        accepted = !model_over() && (bp_queued < fifo_depth);
        drive_guess(l);
        if (accepted) begin
            model_guess(l);
            bp_queued++;
        end
    endtask

    task automatic start_game(input logic [39:0] w);
        while (full) @(negedge clk);
        word     = w;
        new_game = 1'b1;
        @(negedge clk);
        new_game = 1'b0;
        @(negedge clk);
        m_any      = 1'b1;
        m_word     = w;
        m_mask     = '0;
        m_mistakes = 0;
        m_hist     = "______";
    endtask

    task automatic drain();
        check_req = 1'b1;
        wait (check_req == 1'b0);
    endtask

    task automatic finish_test(input string name);
        $display("test %s done, %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    // compares once the fifo has stayed empty for two cycles
    initial begin : compare_rows
        int low_cycles;
        forever begin
            wait (check_req);
            low_cycles = 0;
            while (low_cycles < 2) begin
                @(negedge clk);
                low_cycles = pending ? 0 : low_cycles + 1;
            end
            check_value("rows", rows, expected_rows(m_any, m_word, m_mask, m_hist, m_mistakes));
            check_req = 1'b0;
        end
    end

    initial begin : drive_ready
        lcd_ready = 1'b0;
        forever begin
            @(negedge clk);
            lcd_ready = (ready_mode == 2) || (ready_mode == 1 && $random(seed) % 2 != 0);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: run stopped after %0d cycles, the testbench hung", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        nRst     = 1'b0;
        guess    = 1'b0;
        letter   = 8'h00;
        word     = "hello";
        new_game = 1'b0;
        m_any    = 1'b0;
        m_word   = "hello";
        m_mask   = '0;
        m_hist   = "______";
        m_mistakes = 0;
        bp_queued  = 0;
        repeat (8) @(negedge clk);
        nRst = 1'b1;
        @(negedge clk);

        check_value("rows", rows, '0);
        check_value("full", full, 1'b0);
        check_value("pending", pending, 1'b0);
        start_game("hello");
        drain();
        finish_test("reset");

        send_guess("l");  // double letter
        drain();
        send_guess("h");
        drain();
        send_guess("e");
        drain();
        finish_test("correct guesses");

        start_game("crane");
        drain();
        send_guess("c");
        drain();
        send_guess("x");
        drain();
        send_guess("q");
        drain();
        send_guess("x");  // repeat still costs a mistake
        drain();
        send_guess("z");
        drain();
        send_guess("j");
        drain();
        send_guess("w");  // sixth mistake loses
        drain();
        send_guess("r");  // game over, dropped
        check_value("pending", pending, 1'b0);
        drain();
        finish_test("wrong guesses");

        start_game("sheep");
        drain();
        send_guess("s");
        drain();
        send_guess("k");
        drain();
        send_guess("h");
        drain();
        send_guess("e");
        drain();
        send_guess("p");
        drain();
        start_game("sheep");
        drain();
        finish_test("win");

        start_game("hello");
        drain();
        ready_mode = 0;
        repeat (2) @(negedge clk);
        bp_queued = 0;
        force_guess("h");
        force_guess("z");
        force_guess("q");
        force_guess("x");
        check_value("full", full, bp_queued == fifo_depth);
        force_guess("y");  // no room, dropped
        check_value("full", full, bp_queued == fifo_depth);
        check_value("pending", pending, bp_queued != 0);
        ready_mode = 1;
        drain();
        finish_test("back-pressure");

        for (int g = 0; g < 5; g++) begin
            start_game(words[g % 4]);
            drain();
            for (int k = 0; k < 12 && !model_over(); k++) begin
                send_guess(pick_letter(words[g % 4]));
                drain();
            end
        end
        finish_test("random games");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
design/hangman_pkg.sv
design/guess_checker.sv
design/event_fifo.sv
design/host_display.sv
design/hangman_host.sv
sim/tb_clock.sv
sim/hangman_asserts.sv
sim/hangman_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = hangman_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
